/* all.f */
huff_pkg.sv
freq_counter.sv
least_finder.sv
tree_builder.sv
huff_ctrl.sv
huff_top.sv
tb_huff.sv

/* freq_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module freq_counter (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       clear,      // First symbol of a new run
  input  wire logic                       sym_valid,
  input  wire logic [huff_pkg::SYM_W-1:0] sym,
  input  wire logic [huff_pkg::SYM_W-1:0] rd_sym,     // Finder read address
  output logic [huff_pkg::FREQ_W-1:0]     rd_freq
);
  import huff_pkg::*;

  // One counter per symbol
  logic [FREQ_W-1:0] hist [ALPHABET];

  always_ff @(posedge clk, posedge rst_n) begin
    if (rst_n) begin
      for (int i = 0; i < ALPHABET; i++) begin
        hist[i] <= '0;
      end
    end else begin
      // Wipe the old run
      if (clear) begin
        for (int i = 0; i < ALPHABET; i++) begin
          hist[i] <= '0;
        end
      end
      if (sym_valid) begin
        if (clear) begin
          hist[sym] <= FREQ_W'(1);                  // Counts on top of the wipe
        end else if (hist[sym] != '1) begin
          hist[sym] <= hist[sym] + 1'b1;            // Saturate at all ones
        end
      end
    end
  end

  // Combinational read for the scan
  assign rd_freq = hist[rd_sym];

endmodule

`default_nettype wire

/* huff_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module huff_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic sym_valid,
  input  wire logic sym_last,
  input  wire logic merge_done,
  input  wire logic build_end,
  output logic      clear,
  output logic      scan_start,
  output logic      tree_done
);
  import huff_pkg::*;

  logic [1:0] state;
  logic       kick;                           // Delays first scan past the last count

  // New run begins on any symbol seen while idle or done
  assign clear     = sym_valid && ((state == ST_IDLE) || (state == ST_DONE));
  assign tree_done = (state == ST_DONE);

  always_ff @(posedge clk, posedge rst_n) begin
    if (rst_n) begin
      state      <= ST_IDLE;
      kick       <= 1'b0;
      scan_start <= 1'b0;
    end else begin
      kick       <= 1'b0;
      scan_start <= kick || ((state == ST_SCAN) && merge_done);   // Chain the next scan
      case (state)
        ST_IDLE, ST_DONE: if (sym_valid) begin
          state <= sym_last ? ST_SCAN : ST_COUNT;                  // One-symbol stream too
          kick  <= sym_last;
        end
        ST_COUNT: if (sym_valid && sym_last) begin
          state <= ST_SCAN;
          kick  <= 1'b1;
        end
        default: if (build_end) state <= ST_DONE;                  // Symbols ignored here
      endcase
    end
  end

endmodule

`default_nettype wire

/* huff_pkg.sv */
`default_nettype none

package huff_pkg;

  // Alphabet and table sizes
  localparam int SYM_W    = 7;              // Symbols are 7 bits wide
  localparam int ALPHABET = 128;            // One histogram entry per symbol
  localparam int IDX_W    = 7;              // Sum node index width
  localparam int MAX_SUM  = 128;            // Sum node slots in the finder
  localparam int SCAN_W   = IDX_W + 1;      // Top bit picks leaf half or sum half
  localparam int FREQ_W   = 24;             // Frequency width, counters saturate

  // Output credits
  localparam int NODE_CREDITS = 2;
  localparam int CREDIT_W     = $clog2(NODE_CREDITS + 1);

  // Node reference, 9 bits
  localparam int REF_W = 9;

  // Node word is {index, left, right, freq}
  localparam int NW_FREQ_LSB  = 0;
  localparam int NW_RIGHT_LSB = NW_FREQ_LSB + FREQ_W;
  localparam int NW_LEFT_LSB  = NW_RIGHT_LSB + REF_W;
  localparam int NW_INDEX_LSB = NW_LEFT_LSB + REF_W;
  localparam int NODE_W       = NW_INDEX_LSB + IDX_W;   // 49 bits

  // Controller phases
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_COUNT = 2'd1;
  localparam logic [1:0] ST_SCAN  = 2'd2;   // Scan or merge in flight
  localparam logic [1:0] ST_DONE  = 2'd3;

  // Bit 8 tells which view applies
  typedef union packed {
    struct packed {
      logic       is_sum;                   // Clear for a leaf
      logic [7:0] sym;                      // Symbol in the low bits
    } leaf;
    struct packed {
      logic       is_sum;                   // Set for a sum node
      logic       is_null;                  // Set together with is_sum for no node
      logic [6:0] index;                    // Sum slot number
    } sum;
  } node_ref_t;

  // No node at all
  localparam node_ref_t NULL_REF = 9'b1_1000_0000;

endpackage

`default_nettype wire

/* huff_top.sv */
`timescale 1ns/1ns
`default_nettype none

module huff_top (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       sym_valid,
  input  wire logic [huff_pkg::SYM_W-1:0] sym,
  input  wire logic                       sym_last,
  input  wire logic                       credit_return,
  output logic                            node_valid,
  output logic [huff_pkg::NODE_W-1:0]     node_word,
  output logic                            tree_done
);
  import huff_pkg::*;

  logic              clear, scan_start, pair_valid, merge_done, build_end;
  logic [SYM_W-1:0]  rd_sym;
  logic [FREQ_W-1:0] rd_freq, pair_sum, new_freq;
  logic [IDX_W-1:0]  new_index;
  node_ref_t         least1, least2;

  // Histogram
  freq_counter freq_counter_inst (
    .clk(clk), .rst_n(rst_n), .clear(clear), .sym_valid(sym_valid), .sym(sym),
    .rd_sym(rd_sym), .rd_freq(rd_freq)
  );

  // Pair search over leaves and sum slots
  least_finder least_finder_inst (
    .clk(clk), .rst_n(rst_n), .scan_start(scan_start), .rd_sym(rd_sym), .rd_freq(rd_freq),
    .merge_done(merge_done), .new_index(new_index), .new_freq(new_freq),
    .pair_valid(pair_valid), .least1(least1), .least2(least2), .pair_sum(pair_sum)
  );

  // Merge and credit-gated output
  tree_builder tree_builder_inst (
    .clk(clk), .rst_n(rst_n), .pair_valid(pair_valid), .least1(least1), .least2(least2),
    .pair_sum(pair_sum), .credit_return(credit_return), .node_valid(node_valid),
    .node_word(node_word), .merge_done(merge_done), .new_index(new_index),
    .new_freq(new_freq), .build_end(build_end)
  );

  huff_ctrl huff_ctrl_inst (
    .clk(clk), .rst_n(rst_n), .sym_valid(sym_valid), .sym_last(sym_last),
    .merge_done(merge_done), .build_end(build_end), .clear(clear),
    .scan_start(scan_start), .tree_done(tree_done)
  );

endmodule

`default_nettype wire

/* least_finder.sv */
`timescale 1ns/1ns
`default_nettype none

module least_finder (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        scan_start,
  output logic [huff_pkg::SYM_W-1:0]       rd_sym,
  input  wire logic [huff_pkg::FREQ_W-1:0] rd_freq,
  input  wire logic                        merge_done,
  input  wire logic [huff_pkg::IDX_W-1:0]  new_index,
  input  wire logic [huff_pkg::FREQ_W-1:0] new_freq,
  output logic                             pair_valid,
  output huff_pkg::node_ref_t              least1,
  output huff_pkg::node_ref_t              least2,
  output logic [huff_pkg::FREQ_W-1:0]      pair_sum
);
  import huff_pkg::*;

  logic              busy;
  logic [SCAN_W-1:0] ptr;                          // Leaves first, then sum slots
  logic [ALPHABET-1:0] leaf_closed;
  logic [MAX_SUM-1:0]  sum_open;                   // Written and not yet merged
  logic [FREQ_W-1:0] sum_freq [MAX_SUM];
  logic [FREQ_W-1:0] f1, f2;                       // Frequencies of the best two
  node_ref_t         cand;
  logic [FREQ_W-1:0] cand_f;
  logic              cand_ok;
  logic              beats1, beats2;
  logic              tree_end;

  assign rd_sym = ptr[SYM_W-1:0];

  // Decode the entry under the pointer
  always_comb begin
    cand = NULL_REF;
    if (!ptr[IDX_W]) begin
      cand.leaf.is_sum = 1'b0;
      cand.leaf.sym    = (REF_W-1)'(ptr[SYM_W-1:0]);
      cand_f  = rd_freq;
      cand_ok = (rd_freq != '0) && !leaf_closed[ptr[SYM_W-1:0]];   // Absent or merged
    end else begin
      cand.sum.is_sum  = 1'b1;
      cand.sum.is_null = 1'b0;
      cand.sum.index   = ptr[IDX_W-1:0];
      cand_f  = sum_freq[ptr[IDX_W-1:0]];
      cand_ok = sum_open[ptr[IDX_W-1:0]];
    end
  end

  // Strictly lower only, so scan order settles ties
  assign beats1 = (least1 == NULL_REF) || (cand_f < f1);
  assign beats2 = (least2 == NULL_REF) || (cand_f < f2);

  assign pair_sum = f1 + f2;                       // Missing side counts as zero
  // Lone sum node or nothing left means the tree is finished
  assign tree_end = (least2 == NULL_REF) && least1.sum.is_sum;

  always_ff @(posedge clk, posedge rst_n) begin
    if (rst_n) begin
      busy        <= 1'b0;
      ptr         <= '0;
      pair_valid  <= 1'b0;
      least1      <= NULL_REF;
      least2      <= NULL_REF;
      f1          <= '0;
      f2          <= '0;
      leaf_closed <= '0;
      sum_open    <= '0;
    end else begin
      pair_valid <= 1'b0;
      if (scan_start) begin
        busy   <= 1'b1;
        ptr    <= '0;
        least1 <= NULL_REF;
        least2 <= NULL_REF;
        f1     <= '0;
        f2     <= '0;
      end else if (busy) begin
        if (cand_ok && beats1) begin
          least2 <= least1;                        // Old best slides down
          f2     <= f1;
          least1 <= cand;
          f1     <= cand_f;
        end else if (cand_ok && beats2) begin
          least2 <= cand;
          f2     <= cand_f;
        end
        ptr <= ptr + 1'b1;
        if (ptr == '1) begin
          busy       <= 1'b0;
          pair_valid <= 1'b1;
        end
      end
      // Retire the merged pair and open the new node
      if (merge_done) begin
        sum_open[new_index] <= 1'b1;
        if (!least1.leaf.is_sum) leaf_closed[least1.leaf.sym[SYM_W-1:0]] <= 1'b1;
        else if (!least1.sum.is_null) sum_open[least1.sum.index] <= 1'b0;
        if (!least2.leaf.is_sum) leaf_closed[least2.leaf.sym[SYM_W-1:0]] <= 1'b1;
        else if (!least2.sum.is_null) sum_open[least2.sum.index] <= 1'b0;
      end
      if (pair_valid && tree_end) begin
        leaf_closed <= '0;                         // Fresh tables for the next run
        sum_open    <= '0;
      end
    end
  end

  // Sum frequency table
  always_ff @(posedge clk) begin
    if (merge_done) sum_freq[new_index] <= new_freq;
  end

  // A real node is never paired with itself
  a_pair_distinct: assert property (@(posedge clk) disable iff (rst_n)
    (pair_valid && least1 != NULL_REF) |-> (least1 != least2));

endmodule

`default_nettype wire

/* tb_huff.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_huff;
  import huff_pkg::*;

  localparam int LEN_RAND = 300;                 // Wide random stream over all symbols
  localparam int LEN_ONE  = 5;                   // Only one distinct symbol
  localparam int LEN_HOLD = 200;                 // Stream built while credits are held back
  localparam int HOLD_CYC = 2000;
  localparam logic [31:0] SEED = 32'h94f670e7;
  // Scan budget per node, node bound per run plus one closing scan each
  localparam int WATCHDOG_CYCLES = (ALPHABET + MAX_SUM + 8) * (ALPHABET + 1 + 32 + 3)
                                   + LEN_RAND + LEN_ONE + LEN_HOLD + HOLD_CYC + 100;

  logic              clk, rst_n, sym_valid, sym_last, credit_return;
  logic              node_valid, tree_done;
  logic [SYM_W-1:0]  sym;
  logic [NODE_W-1:0] node_word, last_word;
  logic [NODE_W-1:0] exp_words [MAX_SUM+1];      // Expected node sequence of the run
  int                tb_hist [ALPHABET];
  int                exp_count, run_base, emitted, returned, issued, delay;
  bit                hold_credits;
  integer            stim_seed, credit_seed;

  huff_top huff_top_inst (
    .clk(clk), .rst_n(rst_n), .sym_valid(sym_valid), .sym(sym), .sym_last(sym_last),
    .credit_return(credit_return), .node_valid(node_valid), .node_word(node_word),
    .tree_done(tree_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else stop_with_error($sformatf("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp));
  endtask

  // Lower frequency first; leaves are numbered below sum slots
  function automatic bit precedes(input int fa, input int ca, input int fb, input int cb);
    return (fa < fb) || ((fa == fb) && (ca < cb));
  endfunction

  function automatic logic [REF_W-1:0] make_ref(input int c);
    if (c < 0) return NULL_REF;
    else if (c < ALPHABET) return {1'b0, 8'(c)};            // Leaf view
    else return {2'b10, 7'(c - ALPHABET)};                   // Sum view
  endfunction

  // Replays the tree build from the testbench histogram
  function automatic int build_expected();
    bit                leaf_open [ALPHABET];
    bit                slot_open [MAX_SUM];
    int                slot_f [MAX_SUM];
    int                n, f, idx, f1, f2, c1, c2;
    bit                finished, is_sum, ok;
    logic [NODE_W-1:0] w;
    n = 0;
    finished = 1'b0;
    for (int i = 0; i < ALPHABET; i++) leaf_open[i] = (tb_hist[i] != 0);
    for (int i = 0; i < MAX_SUM; i++) slot_open[i] = 1'b0;
    while (!finished) begin
      c1 = -1;
      c2 = -1;
      f1 = 0;
      f2 = 0;
      for (int c = 0; c < ALPHABET + MAX_SUM; c++) begin
        is_sum = (c >= ALPHABET);
        idx    = is_sum ? c - ALPHABET : c;
        ok     = is_sum ? slot_open[idx] : leaf_open[idx];
        f      = is_sum ? slot_f[idx] : tb_hist[idx];
        if (ok && (c1 < 0 || precedes(f, c, f1, c1))) begin
          c2 = c1;                                           // Old best becomes second
          f2 = f1;
          c1 = c;
          f1 = f;
        end else if (ok && (c2 < 0 || precedes(f, c, f2, c2))) begin
          c2 = c;
          f2 = f;
        end
      end
      // Nothing open, or a lone sum node that is the root
      if (c1 < 0 || (c2 < 0 && c1 >= ALPHABET)) begin
        finished = 1'b1;
      end else begin
        w = '0;
        w[NW_INDEX_LSB +: IDX_W]  = IDX_W'(n);
        w[NW_LEFT_LSB  +: REF_W]  = make_ref(c1);
        w[NW_RIGHT_LSB +: REF_W]  = make_ref(c2);            // Null when c2 missing
        w[NW_FREQ_LSB  +: FREQ_W] = FREQ_W'(f1 + f2);
        exp_words[n] = w;
        if (c1 < ALPHABET) leaf_open[c1] = 1'b0;
        else slot_open[c1 - ALPHABET] = 1'b0;
        if (c2 >= ALPHABET) slot_open[c2 - ALPHABET] = 1'b0;
        else if (c2 >= 0) leaf_open[c2] = 1'b0;
        slot_open[n] = 1'b1;
        slot_f[n]    = f1 + f2;
        n++;
      end
    end
    return n;
  endfunction

  // Compares every emitted node and keeps the credit tally
  always @(posedge clk) begin : compare
    int k;
    if (rst_n == 1'b0) begin
      if (node_valid) begin
        k = emitted - run_base;
        assert (emitted < NODE_CREDITS + returned)
          else stop_with_error("Node emitted while the consumer held no free slot");
        assert (k < exp_count)
          else stop_with_error("More nodes emitted than the reference tree holds");
        check_value("node_word.index", node_word[NW_INDEX_LSB +: IDX_W],
                    exp_words[k][NW_INDEX_LSB +: IDX_W]);
        check_value("node_word.left", node_word[NW_LEFT_LSB +: REF_W],
                    exp_words[k][NW_LEFT_LSB +: REF_W]);
        check_value("node_word.right", node_word[NW_RIGHT_LSB +: REF_W],
                    exp_words[k][NW_RIGHT_LSB +: REF_W]);
        check_value("node_word.freq", node_word[NW_FREQ_LSB +: FREQ_W],
                    exp_words[k][NW_FREQ_LSB +: FREQ_W]);
        last_word = node_word;
        emitted++;
      end
      if (credit_return) returned++;                         // Counted after the emit check
    end
  end

  // Consumer returns one slot per node after a random delay
  always @(negedge clk) begin
    if (rst_n == 1'b0) begin
      credit_return = 1'b0;
      if (delay > 0) delay--;
      else if (!hold_credits && issued < emitted) begin
        credit_return = 1'b1;
        issued++;
        delay = $unsigned($random(credit_seed)) % 4;
      end
    end
  end

  task automatic run_stream(input int len, input int mask, input bit withhold);
    int stream [LEN_RAND];
    int offset, distinct;
    while (issued != emitted) @(negedge clk);                // All slots home first
    offset = $unsigned($random(stim_seed)) & ~mask & (ALPHABET - 1);
    distinct = 0;
    foreach (tb_hist[i]) tb_hist[i] = 0;
    for (int i = 0; i < len; i++) begin
      stream[i] = ($unsigned($random(stim_seed)) & mask) | offset;
      tb_hist[stream[i]]++;
    end
    foreach (tb_hist[i]) if (tb_hist[i] != 0) distinct++;
    exp_count    = build_expected();
    run_base     = emitted;
    hold_credits = withhold;
    for (int i = 0; i < len; i++) begin
      sym_valid = 1'b1;
      sym       = SYM_W'(stream[i]);
      sym_last  = (i == len - 1);
      @(negedge clk);
    end
    sym_valid = 1'b0;
    sym_last  = 1'b0;
    if (withhold) begin
      repeat (HOLD_CYC) @(negedge clk);
      check_value("stalled node count", emitted - run_base,
                  (exp_count < NODE_CREDITS) ? exp_count : NODE_CREDITS);
      hold_credits = 1'b0;                                   // Let the build resume
    end
    while (!tree_done) @(negedge clk);
    check_value("node count", emitted - run_base, exp_count);
    check_value("node count vs distinct", emitted - run_base, (distinct > 1) ? distinct - 1 : 1);
    check_value("root freq", last_word[NW_FREQ_LSB +: FREQ_W], len);
    if (distinct == 1) check_value("root right ref", last_word[NW_RIGHT_LSB +: REF_W], NULL_REF);
  endtask

  initial begin
    stim_seed     = SEED;
    credit_seed   = SEED;
    rst_n         = 1'b1;                                    // Reset is active high
    sym_valid     = 1'b0;
    sym           = '0;
    sym_last      = 1'b0;
    credit_return = 1'b0;
    emitted       = 0;
    returned      = 0;
    issued        = 0;
    delay         = 0;
    run_base      = 0;
    exp_count     = 0;
    hold_credits  = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    run_stream(LEN_RAND, ALPHABET - 1, 1'b0);
    run_stream(LEN_ONE, 0, 1'b0);                            // One symbol, root pairs with null
    run_stream(LEN_HOLD, 31, 1'b1);
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_error("Tree construction did not finish before the watchdog limit");
  end

endmodule

`default_nettype wire

/* tree_builder.sv */
`timescale 1ns/1ns
`default_nettype none

module tree_builder (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        pair_valid,
  input  wire huff_pkg::node_ref_t         least1,
  input  wire huff_pkg::node_ref_t         least2,
  input  wire logic [huff_pkg::FREQ_W-1:0] pair_sum,
  input  wire logic                        credit_return,   // One slot back per pulse
  output logic                             node_valid,
  output logic [huff_pkg::NODE_W-1:0]      node_word,
  output logic                             merge_done,
  output logic [huff_pkg::IDX_W-1:0]       new_index,
  output logic [huff_pkg::FREQ_W-1:0]      new_freq,
  output logic                             build_end
);
  import huff_pkg::*;

  logic                pending;                 // Node formed, waiting for a credit
  logic [CREDIT_W-1:0] credits;
  logic [IDX_W-1:0]    next_index;              // Sum nodes numbered from zero
  logic [NODE_W-1:0]   word_next;
  logic                tree_end;

  // Leaf plus null still makes a root, lone sum node is the root already
  assign tree_end = (least2 == NULL_REF) && least1.sum.is_sum;

  always_comb begin
    word_next = '0;
    word_next[NW_INDEX_LSB +: IDX_W]  = next_index;
    word_next[NW_LEFT_LSB  +: REF_W]  = least1;
    word_next[NW_RIGHT_LSB +: REF_W]  = least2;
    word_next[NW_FREQ_LSB  +: FREQ_W] = pair_sum;
  end

  // Emit only with a credit in hand, otherwise the whole build stalls
  assign node_valid = pending && (credits != '0);
  assign merge_done = node_valid;
  assign new_index  = node_word[NW_INDEX_LSB +: IDX_W];
  assign new_freq   = node_word[NW_FREQ_LSB +: FREQ_W];

  always_ff @(posedge clk, posedge rst_n) begin
    if (rst_n) begin
      pending    <= 1'b0;
      build_end  <= 1'b0;
      credits    <= CREDIT_W'(NODE_CREDITS);
      next_index <= '0;
    end else begin
      build_end <= pair_valid && tree_end;
      credits   <= credits - CREDIT_W'(node_valid) + CREDIT_W'(credit_return);
      if (pair_valid && !tree_end) pending <= 1'b1;
      else if (node_valid) pending <= 1'b0;
      if (node_valid) next_index <= next_index + 1'b1;
      else if (build_end) next_index <= '0;        // Next run restarts at zero
    end
  end

  // Held stable until emitted
  always_ff @(posedge clk) begin
    if (pair_valid && !tree_end) node_word <= word_next;
  end

  // Consumer never returns more than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (rst_n)
    credits <= CREDIT_W'(NODE_CREDITS));

  // Out of credits the formed node waits, no new pair may overwrite it
  a_stall_hold: assert property (@(posedge clk) disable iff (rst_n)
    (pending && (credits == '0)) |=> (pending && $stable(node_word)));

endmodule

`default_nettype wire
